/* include/commit_settings.svh */
`ifndef COMMIT_SETTINGS_SVH
`define COMMIT_SETTINGS_SVH

// Result word width in bits.
`define COMMIT_DATA_W 32

// Architectural register index width (32 registers).
`define COMMIT_REG_W 5

// ROB slot index width (64 slots).
`define COMMIT_TAG_W 6

// Entries in each commit buffer.
`define COMMIT_DEPTH 4

`endif

/* hdl/commit_pkg.sv */
`include "commit_settings.svh"

package commit_pkg;

    // Result produced by an execution unit.
    typedef logic [`COMMIT_DATA_W-1:0] data_word_t;

    // Destination or source register index.
    typedef logic [`COMMIT_REG_W-1:0] reg_addr_t;

    // Slot of the instruction in the reorder buffer.
    typedef logic [`COMMIT_TAG_W-1:0] rob_tag_t;

    // Which commit buffer owns the ROB write port this cycle.
    typedef enum logic {
        TURN_ITU = 1'b0,  // Merged ITU/CSR channel.
        TURN_LSU = 1'b1   // Load/store channel.
    } arb_state_t;

endpackage : commit_pkg

/* hdl/commit_buffer.sv */
`include "commit_settings.svh"

module commit_buffer #(
    parameter int unsigned DEPTH = `COMMIT_DEPTH
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    input  logic                   push_i,
    input  commit_pkg::data_word_t push_result_i,
    input  commit_pkg::reg_addr_t  push_reg_i,
    input  commit_pkg::rob_tag_t   push_tag_i,
    input  logic                   pop_i,
    output commit_pkg::data_word_t head_result_o,
    output commit_pkg::reg_addr_t  head_reg_o,
    output commit_pkg::rob_tag_t   head_tag_o,
    input  logic                   inval_i,
    input  commit_pkg::reg_addr_t  inval_reg_i,
    input  commit_pkg::reg_addr_t  src0_i,
    input  commit_pkg::reg_addr_t  src1_i,
    output logic                   hit0_o,
    output logic                   hit1_o,
    output commit_pkg::data_word_t hit_data0_o,
    output commit_pkg::data_word_t hit_data1_o,
    output logic                   full_o,
    output logic                   empty_o
);

    import commit_pkg::*;

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;

    data_word_t result_mem [DEPTH];  // Payload storage.
    reg_addr_t  reg_mem    [DEPTH];
    rob_tag_t   tag_mem    [DEPTH];

    logic [DEPTH-1:0] elig_q;  // Entry may still feed a forward.
    ptr_t             rd_ptr_q, wr_ptr_q;
    logic [CNT_W-1:0] count_q;

    // Advance a pointer with wrap at DEPTH.
    function automatic ptr_t ptr_next(ptr_t ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk_i) begin : pointers
        if (!rst_n_i || flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) wr_ptr_q <= ptr_next(wr_ptr_q);
            if (pop_i) rd_ptr_q <= ptr_next(rd_ptr_q);
            count_q <= count_q + CNT_W'(push_i) - CNT_W'(pop_i);
        end
    end : pointers

    always_ff @(posedge clk_i) begin : storage
        if (push_i) begin
            result_mem[wr_ptr_q] <= push_result_i;
            reg_mem[wr_ptr_q]    <= push_reg_i;
            tag_mem[wr_ptr_q]    <= push_tag_i;
        end
    end : storage

    // A newer write to the same register, here or on the other
    // channel, makes older entries stale for forwarding.
    always_ff @(posedge clk_i) begin : eligibility
        if (!rst_n_i || flush_i) begin
            elig_q <= '0;
        end else begin
            for (int unsigned i = 0; i < DEPTH; i++) begin
                if ((inval_i && reg_mem[i] == inval_reg_i) ||
                    (push_i && reg_mem[i] == push_reg_i)) begin
                    elig_q[i] <= 1'b0;
                end
            end
            if (pop_i) elig_q[rd_ptr_q] <= 1'b0;  // Leaves for the ROB.
            if (push_i) elig_q[wr_ptr_q] <= 1'b1;  // New entry wins.
        end
    end : eligibility

    // Scan oldest to youngest, so the last match is the newest one.
    always_comb begin : fwd_search
        int unsigned idx;
        hit0_o      = 1'b0;
        hit1_o      = 1'b0;
        hit_data0_o = '0;
        hit_data1_o = '0;
        for (int unsigned age = 0; age < DEPTH; age++) begin
            idx = (rd_ptr_q + age) % DEPTH;
            if (elig_q[idx] && reg_mem[idx] == src0_i) begin
                hit0_o      = 1'b1;
                hit_data0_o = result_mem[idx];
            end
            if (elig_q[idx] && reg_mem[idx] == src1_i) begin
                hit1_o      = 1'b1;
                hit_data1_o = result_mem[idx];
            end
        end
    end : fwd_search

    assign head_result_o = result_mem[rd_ptr_q];  // First word falls through.
    assign head_reg_o    = reg_mem[rd_ptr_q];
    assign head_tag_o    = tag_mem[rd_ptr_q];

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);

    // Producers must honour stall, and the arbiter pops only a full head.
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i && !flush_i |-> !full_o);
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_i |-> !empty_o);

endmodule : commit_buffer

/* hdl/commit_arbiter.sv */
module commit_arbiter (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    input  logic                   itu_valid_i,
    input  commit_pkg::data_word_t itu_result_i,
    input  commit_pkg::reg_addr_t  itu_reg_i,
    input  commit_pkg::rob_tag_t   itu_tag_i,
    input  logic                   itu_empty_i,
    input  commit_pkg::data_word_t itu_head_result_i,
    input  commit_pkg::reg_addr_t  itu_head_reg_i,
    input  commit_pkg::rob_tag_t   itu_head_tag_i,
    input  logic                   lsu_valid_i,
    input  commit_pkg::data_word_t lsu_result_i,
    input  commit_pkg::reg_addr_t  lsu_reg_i,
    input  commit_pkg::rob_tag_t   lsu_tag_i,
    input  logic                   lsu_empty_i,
    input  commit_pkg::data_word_t lsu_head_result_i,
    input  commit_pkg::reg_addr_t  lsu_head_reg_i,
    input  commit_pkg::rob_tag_t   lsu_head_tag_i,
    output logic                   itu_push_o,
    output logic                   itu_pop_o,
    output logic                   lsu_push_o,
    output logic                   lsu_pop_o,
    output logic                   rob_write_o,
    output commit_pkg::rob_tag_t   rob_tag_o,
    output commit_pkg::data_word_t rob_result_o,
    output commit_pkg::reg_addr_t  rob_reg_o
);

    import commit_pkg::*;

    arb_state_t state_q, state_d;
    logic       itu_bypass, lsu_bypass;  // Incoming result goes straight to the ROB.

    always_ff @(posedge clk_i) begin : state_reg
        if (!rst_n_i || flush_i) begin
            state_q <= TURN_ITU;
        end else begin
            state_q <= state_d;
        end
    end : state_reg

    always_comb begin : serve
        state_d      = state_q;
        itu_pop_o    = 1'b0;
        lsu_pop_o    = 1'b0;
        itu_bypass   = 1'b0;
        lsu_bypass   = 1'b0;
        rob_write_o  = 1'b0;
        rob_tag_o    = '0;
        rob_result_o = '0;
        rob_reg_o    = '0;
        if (!flush_i) begin  // Nothing commits while flushing.
            case (state_q)
                TURN_ITU: begin
                    if (!itu_empty_i) begin
                        itu_pop_o    = 1'b1;  // Oldest buffered first.
                        rob_write_o  = 1'b1;
                        rob_tag_o    = itu_head_tag_i;
                        rob_result_o = itu_head_result_i;
                        rob_reg_o    = itu_head_reg_i;
                    end else if (itu_valid_i) begin
                        itu_bypass   = 1'b1;
                        rob_write_o  = 1'b1;
                        rob_tag_o    = itu_tag_i;
                        rob_result_o = itu_result_i;
                        rob_reg_o    = itu_reg_i;
                    end
                    if (!lsu_empty_i) state_d = TURN_LSU;  // Hand over the turn.
                end
                TURN_LSU: begin
                    if (!lsu_empty_i) begin
                        lsu_pop_o    = 1'b1;
                        rob_write_o  = 1'b1;
                        rob_tag_o    = lsu_head_tag_i;
                        rob_result_o = lsu_head_result_i;
                        rob_reg_o    = lsu_head_reg_i;
                    end else if (lsu_valid_i) begin
                        lsu_bypass   = 1'b1;
                        rob_write_o  = 1'b1;
                        rob_tag_o    = lsu_tag_i;
                        rob_result_o = lsu_result_i;
                        rob_reg_o    = lsu_reg_i;
                    end
                    if (!itu_empty_i) state_d = TURN_ITU;
                end
                default: state_d = TURN_ITU;
            endcase
        end
    end : serve

    assign itu_push_o = itu_valid_i && !itu_bypass;  // Everything not bypassed waits.
    assign lsu_push_o = lsu_valid_i && !lsu_bypass;

    // A waiting buffer not served now gets the ROB port in the next cycle.
    assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
        !itu_empty_i && !itu_pop_o |=> itu_pop_o);
    assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
        !lsu_empty_i && !lsu_pop_o |=> lsu_pop_o);

endmodule : commit_arbiter

/* hdl/forward_select.sv */
module forward_select (
    input  logic                   itu_valid_i,
    input  commit_pkg::reg_addr_t  itu_reg_i,
    input  commit_pkg::data_word_t itu_result_i,
    input  logic                   lsu_valid_i,
    input  commit_pkg::reg_addr_t  lsu_reg_i,
    input  commit_pkg::data_word_t lsu_result_i,
    input  commit_pkg::reg_addr_t  src0_i,
    input  commit_pkg::reg_addr_t  src1_i,
    input  logic                   itu_hit0_i,
    input  logic                   itu_hit1_i,
    input  commit_pkg::data_word_t itu_hit_data0_i,
    input  commit_pkg::data_word_t itu_hit_data1_i,
    input  logic                   lsu_hit0_i,
    input  logic                   lsu_hit1_i,
    input  commit_pkg::data_word_t lsu_hit_data0_i,
    input  commit_pkg::data_word_t lsu_hit_data1_i,
    output commit_pkg::data_word_t fwd_data0_o,
    output logic                   fwd_valid0_o,
    output commit_pkg::data_word_t fwd_data1_o,
    output logic                   fwd_valid1_o
);

    import commit_pkg::*;

    reg_addr_t  src      [2];
    logic       itu_hit  [2];
    logic       lsu_hit  [2];
    data_word_t itu_data [2];
    data_word_t lsu_data [2];
    data_word_t fwd_data [2];
    logic       fwd_valid[2];

    // Gather the two queries so both share one selection loop.
    assign src      = '{src0_i, src1_i};
    assign itu_hit  = '{itu_hit0_i, itu_hit1_i};
    assign lsu_hit  = '{lsu_hit0_i, lsu_hit1_i};
    assign itu_data = '{itu_hit_data0_i, itu_hit_data1_i};
    assign lsu_data = '{lsu_hit_data0_i, lsu_hit_data1_i};

    always_comb begin : select
        for (int i = 0; i < 2; i++) begin
            fwd_valid[i] = 1'b1;
            if (itu_valid_i && itu_reg_i == src[i]) begin
                fwd_data[i] = itu_result_i;  // Arriving data is newest.
            end else if (lsu_valid_i && lsu_reg_i == src[i]) begin
                fwd_data[i] = lsu_result_i;
            end else if (itu_hit[i]) begin
                fwd_data[i] = itu_data[i];  // Then the buffers.
            end else if (lsu_hit[i]) begin
                fwd_data[i] = lsu_data[i];
            end else begin
                fwd_data[i]  = '0;
                fwd_valid[i] = 1'b0;  // No pending write.
            end
        end
    end : select

    assign fwd_data0_o  = fwd_data[0];
    assign fwd_valid0_o = fwd_valid[0];
    assign fwd_data1_o  = fwd_data[1];
    assign fwd_valid1_o = fwd_valid[1];

    // Cross-channel invalidation leaves one eligible copy per register.
    assert final (!(itu_hit0_i && lsu_hit0_i));
    assert final (!(itu_hit1_i && lsu_hit1_i));

endmodule : forward_select

/* hdl/commit_stage.sv */
module commit_stage (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    input  logic                   itu_valid_i,
    input  commit_pkg::data_word_t itu_result_i,
    input  commit_pkg::reg_addr_t  itu_reg_i,
    input  commit_pkg::rob_tag_t   itu_tag_i,
    input  logic                   csr_valid_i,
    input  commit_pkg::data_word_t csr_result_i,
    input  commit_pkg::reg_addr_t  csr_reg_i,
    input  commit_pkg::rob_tag_t   csr_tag_i,
    input  logic                   lsu_valid_i,
    input  commit_pkg::data_word_t lsu_result_i,
    input  commit_pkg::reg_addr_t  lsu_reg_i,
    input  commit_pkg::rob_tag_t   lsu_tag_i,
    input  commit_pkg::reg_addr_t  src0_i,
    input  commit_pkg::reg_addr_t  src1_i,
    output logic                   rob_write_o,
    output commit_pkg::rob_tag_t   rob_tag_o,
    output commit_pkg::data_word_t rob_result_o,
    output commit_pkg::reg_addr_t  rob_reg_o,
    output commit_pkg::data_word_t fwd_data0_o,
    output logic                   fwd_valid0_o,
    output commit_pkg::data_word_t fwd_data1_o,
    output logic                   fwd_valid1_o,
    output logic                   stall_o
);

    import commit_pkg::*;

    // ITU and CSR never fire together, so one channel carries both.
    logic       mrg_valid;
    data_word_t mrg_result;
    reg_addr_t  mrg_reg;
    rob_tag_t   mrg_tag;

    logic       itu_push, itu_pop, itu_full, itu_empty, itu_hit0, itu_hit1;
    logic       lsu_push, lsu_pop, lsu_full, lsu_empty, lsu_hit0, lsu_hit1;
    data_word_t itu_head_result, itu_hit_data0, itu_hit_data1;
    data_word_t lsu_head_result, lsu_hit_data0, lsu_hit_data1;
    reg_addr_t  itu_head_reg, lsu_head_reg;
    rob_tag_t   itu_head_tag, lsu_head_tag;

    assign mrg_valid  = itu_valid_i | csr_valid_i;
    assign mrg_result = (itu_valid_i ? itu_result_i : '0) | (csr_valid_i ? csr_result_i : '0);
    assign mrg_reg    = (itu_valid_i ? itu_reg_i : '0) | (csr_valid_i ? csr_reg_i : '0);
    assign mrg_tag    = (itu_valid_i ? itu_tag_i : '0) | (csr_valid_i ? csr_tag_i : '0);

    commit_buffer itu_buffer (
        .clk_i, .rst_n_i, .flush_i,
        .push_i        (itu_push),
        .push_result_i (mrg_result),
        .push_reg_i    (mrg_reg),
        .push_tag_i    (mrg_tag),
        .pop_i         (itu_pop),
        .head_result_o (itu_head_result),
        .head_reg_o    (itu_head_reg),
        .head_tag_o    (itu_head_tag),
        .inval_i       (lsu_valid_i),  // LSU result is newer.
        .inval_reg_i   (lsu_reg_i),
        .src0_i, .src1_i,
        .hit0_o        (itu_hit0),
        .hit1_o        (itu_hit1),
        .hit_data0_o   (itu_hit_data0),
        .hit_data1_o   (itu_hit_data1),
        .full_o        (itu_full),
        .empty_o       (itu_empty)
    );

    commit_buffer lsu_buffer (
        .clk_i, .rst_n_i, .flush_i,
        .push_i        (lsu_push),
        .push_result_i (lsu_result_i),
        .push_reg_i    (lsu_reg_i),
        .push_tag_i    (lsu_tag_i),
        .pop_i         (lsu_pop),
        .head_result_o (lsu_head_result),
        .head_reg_o    (lsu_head_reg),
        .head_tag_o    (lsu_head_tag),
        .inval_i       (mrg_valid),  // Merged result is newer.
        .inval_reg_i   (mrg_reg),
        .src0_i, .src1_i,
        .hit0_o        (lsu_hit0),
        .hit1_o        (lsu_hit1),
        .hit_data0_o   (lsu_hit_data0),
        .hit_data1_o   (lsu_hit_data1),
        .full_o        (lsu_full),
        .empty_o       (lsu_empty)
    );

    commit_arbiter arbiter0 (
        .clk_i, .rst_n_i, .flush_i,
        .itu_valid_i       (mrg_valid),
        .itu_result_i      (mrg_result),
        .itu_reg_i         (mrg_reg),
        .itu_tag_i         (mrg_tag),
        .itu_empty_i       (itu_empty),
        .itu_head_result_i (itu_head_result),
        .itu_head_reg_i    (itu_head_reg),
        .itu_head_tag_i    (itu_head_tag),
        .lsu_valid_i, .lsu_result_i, .lsu_reg_i, .lsu_tag_i,
        .lsu_empty_i       (lsu_empty),
        .lsu_head_result_i (lsu_head_result),
        .lsu_head_reg_i    (lsu_head_reg),
        .lsu_head_tag_i    (lsu_head_tag),
        .itu_push_o        (itu_push),
        .itu_pop_o         (itu_pop),
        .lsu_push_o        (lsu_push),
        .lsu_pop_o         (lsu_pop),
        .rob_write_o, .rob_tag_o, .rob_result_o, .rob_reg_o
    );

    forward_select forward0 (
        .itu_valid_i     (mrg_valid),
        .itu_reg_i       (mrg_reg),
        .itu_result_i    (mrg_result),
        .lsu_valid_i, .lsu_reg_i, .lsu_result_i,
        .src0_i, .src1_i,
        .itu_hit0_i      (itu_hit0),
        .itu_hit1_i      (itu_hit1),
        .itu_hit_data0_i (itu_hit_data0),
        .itu_hit_data1_i (itu_hit_data1),
        .lsu_hit0_i      (lsu_hit0),
        .lsu_hit1_i      (lsu_hit1),
        .lsu_hit_data0_i (lsu_hit_data0),
        .lsu_hit_data1_i (lsu_hit_data1),
        .fwd_data0_o, .fwd_valid0_o, .fwd_data1_o, .fwd_valid1_o
    );

    assign stall_o = itu_full | lsu_full;  // Either buffer at capacity.

    // The merge above is only sound with one of ITU/CSR active.
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({itu_valid_i, csr_valid_i}));

endmodule : commit_stage

/* bench/commit_vectors.svh */
`ifndef COMMIT_VECTORS_SVH
`define COMMIT_VECTORS_SVH

// Each row holds sel (0 idle, 1 ITU, 2 CSR), merged reg, merged tag, lsu valid, lsu reg,
// lsu tag, flush, src0, src1, expected fwd_valid0 and expected fwd_valid1.
typedef struct {
    logic [1:0] sel;
    reg_addr_t  mrg_reg;
    rob_tag_t   mrg_tag;
    logic       lsu_v;
    reg_addr_t  lsu_reg;
    rob_tag_t   lsu_tag;
    logic       flush;
    reg_addr_t  src0;
    reg_addr_t  src1;
    logic       exp_v0;
    logic       exp_v1;
} vec_t;

localparam int NUM_VECS = 33;

vec_t vectors [NUM_VECS] = '{
    '{1,  1,  1, 0,  0,  0, 0,  1,  2, 1, 0},  // ITU bypass on an idle stage.
    '{2,  2,  2, 0,  0,  0, 0,  2,  1, 1, 0},  // CSR bypass.
    '{0,  0,  0, 0,  0,  0, 0,  1,  2, 0, 0},
    '{1,  3,  3, 1,  4,  4, 0,  3,  4, 1, 1},  // Both channels together.
    '{1,  5,  5, 1,  6,  6, 0,  4,  6, 1, 1},
    '{0,  0,  0, 0,  0,  0, 0,  4,  3, 1, 0},
    '{0,  0,  0, 0,  0,  0, 0,  6,  4, 1, 0},
    '{1,  7,  7, 1,  8,  8, 0,  7,  8, 1, 1},  // ITU result waits on the LSU turn.
    '{1,  9,  9, 0,  0,  0, 0,  7,  9, 1, 1},
    '{1, 11, 11, 1, 10, 10, 0,  0,  0, 0, 0},  // LSU buffer starts to fill.
    '{0,  0,  0, 1, 12, 12, 0,  0,  0, 0, 0},
    '{1, 14, 14, 1, 13, 13, 0,  0,  0, 0, 0},
    '{0,  0,  0, 1, 15, 15, 0,  0,  0, 0, 0},
    '{1, 17, 17, 1, 16, 16, 0,  0,  0, 0, 0},
    '{0,  0,  0, 1, 18, 18, 0, 13, 11, 1, 0},  // LSU buffer full after this.
    '{0,  0,  0, 0,  0,  0, 0,  0,  0, 0, 0},  // Stalled, nothing pushed.
    '{0,  0,  0, 0,  0,  0, 0,  0,  0, 0, 0},
    '{0,  0,  0, 0,  0,  0, 0,  0,  0, 0, 0},
    '{0,  0,  0, 0,  0,  0, 0,  0,  0, 0, 0},
    '{0,  0,  0, 0,  0,  0, 0, 18, 13, 1, 0},
    '{1, 20, 20, 0,  0,  0, 0, 20,  0, 1, 0},
    '{2, 21, 21, 0,  0,  0, 0, 20,  5, 1, 0},  // r20 held only in a buffer.
    '{0,  0,  0, 1, 21, 22, 0, 21, 20, 1, 1},  // Newer r21 on the LSU side.
    '{0,  0,  0, 0,  0,  0, 0, 21,  0, 1, 0},
    '{0,  0,  0, 0,  0,  0, 0, 21, 20, 1, 0},
    '{0,  0,  0, 0,  0,  0, 0, 21,  0, 0, 0},
    '{1, 26, 26, 1, 27, 27, 0,  0,  0, 0, 0},
    '{1, 28, 28, 1, 29, 29, 0,  0,  0, 0, 0},
    '{0,  0,  0, 1, 30, 30, 0,  0,  0, 0, 0},
    '{1, 31, 31, 1,  1, 32, 0,  0,  0, 0, 0},  // Both buffers hold entries.
    '{0,  0,  0, 0,  0,  0, 1,  0,  0, 0, 0},  // Flush.
    '{1,  3, 33, 0,  0,  0, 0,  3, 30, 1, 0},  // Bypass on the ITU turn.
    '{0,  0,  0, 0,  0,  0, 0, 31,  1, 0, 0}
};

`endif

/* bench/commit_stage_tb.sv */
`include "commit_settings.svh"

module commit_stage_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import commit_pkg::*;

    `include "commit_vectors.svh"

    localparam int CLK_PERIOD  = 20;
    localparam int NUM_REGS    = 1 << `COMMIT_REG_W;
    localparam int DRAIN_LIMIT = 4 * `COMMIT_DEPTH + 4;  // Cycles to empty both buffers.

    logic       clk_i, rst_n_i, flush_i;
    logic       itu_valid_i, csr_valid_i, lsu_valid_i;
    data_word_t itu_result_i, csr_result_i, lsu_result_i;
    reg_addr_t  itu_reg_i, csr_reg_i, lsu_reg_i, src0_i, src1_i;
    rob_tag_t   itu_tag_i, csr_tag_i, lsu_tag_i;
    logic       rob_write_o, fwd_valid0_o, fwd_valid1_o, stall_o;
    rob_tag_t   rob_tag_o;
    data_word_t rob_result_o, fwd_data0_o, fwd_data1_o;
    reg_addr_t  rob_reg_o;

    integer     seed = 32'hfcc57ede;
    arb_state_t model_turn;                // Predicted arbiter turn.
    rob_tag_t   itu_q[$], lsu_q[$];        // Predicted buffer contents.
    data_word_t sb_result [rob_tag_t];     // Issued, not yet committed.
    reg_addr_t  sb_reg    [rob_tag_t];
    logic       pend_valid  [NUM_REGS];    // Newest pending write per register.
    rob_tag_t   pend_tag    [NUM_REGS];
    data_word_t pend_result [NUM_REGS];
    vec_t       idle_row = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
    int         drain_cycles;

    commit_stage dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_write(input logic exp);
        if (rob_write_o !== exp)
            report_failure($sformatf("Fail rob_write_o: got %h expected %h", rob_write_o, exp));
    endtask

    task automatic check_rob(input rob_tag_t tag, input data_word_t result, input reg_addr_t rd);
        if (rob_tag_o !== tag)
            report_failure($sformatf("Fail rob_tag_o: got %h expected %h", rob_tag_o, tag));
        if (rob_result_o !== result)
            report_failure($sformatf("Fail rob_result_o: got %h expected %h",
                                     rob_result_o, result));
        if (rob_reg_o !== rd)
            report_failure($sformatf("Fail rob_reg_o: got %h expected %h", rob_reg_o, rd));
    endtask

    task automatic check_fwd(input int port, input data_word_t data, input logic valid);
        data_word_t got_data;
        logic       got_valid;
        got_data  = (port == 0) ? fwd_data0_o : fwd_data1_o;
        got_valid = (port == 0) ? fwd_valid0_o : fwd_valid1_o;
        if (got_valid !== valid)
            report_failure($sformatf("Fail fwd_valid%0d_o: got %h expected %h",
                                     port, got_valid, valid));
        if (got_data !== data)
            report_failure($sformatf("Fail fwd_data%0d_o: got %h expected %h",
                                     port, got_data, data));
    endtask

    task automatic check_stall(input logic exp);
        if (stall_o !== exp)
            report_failure($sformatf("Fail stall_o: got %h expected %h", stall_o, exp));
    endtask

    // Drives one row at the falling edge, checks it, then steps the models.
    task automatic apply_cycle(input vec_t v);
        data_word_t mrg_res, lsu_res;
        logic       mrg_v, do_write, took_mrg, took_lsu, exp_stall;
        rob_tag_t   wr_tag;
        arb_state_t turn_next;
        mrg_res = $random(seed);
        lsu_res = $random(seed);
        mrg_v   = (v.sel != 2'd0);
        @(negedge clk_i);
        itu_valid_i  = (v.sel == 2'd1);
        itu_result_i = (v.sel == 2'd1) ? mrg_res : '0;
        itu_reg_i    = (v.sel == 2'd1) ? v.mrg_reg : '0;
        itu_tag_i    = (v.sel == 2'd1) ? v.mrg_tag : '0;
        csr_valid_i  = (v.sel == 2'd2);
        csr_result_i = (v.sel == 2'd2) ? mrg_res : '0;
        csr_reg_i    = (v.sel == 2'd2) ? v.mrg_reg : '0;
        csr_tag_i    = (v.sel == 2'd2) ? v.mrg_tag : '0;
        lsu_valid_i  = v.lsu_v;
        lsu_result_i = v.lsu_v ? lsu_res : '0;
        lsu_reg_i    = v.lsu_reg;
        lsu_tag_i    = v.lsu_tag;
        flush_i      = v.flush;
        src0_i       = v.src0;
        src1_i       = v.src1;
        if (mrg_v) begin  // Incoming results are the newest writers.
            sb_result[v.mrg_tag]   = mrg_res;
            sb_reg[v.mrg_tag]      = v.mrg_reg;
            pend_valid[v.mrg_reg]  = 1'b1;
            pend_tag[v.mrg_reg]    = v.mrg_tag;
            pend_result[v.mrg_reg] = mrg_res;
        end
        if (v.lsu_v) begin
            sb_result[v.lsu_tag]   = lsu_res;
            sb_reg[v.lsu_tag]      = v.lsu_reg;
            pend_valid[v.lsu_reg]  = 1'b1;
            pend_tag[v.lsu_reg]    = v.lsu_tag;
            pend_result[v.lsu_reg] = lsu_res;
        end
        exp_stall = (itu_q.size() == `COMMIT_DEPTH) || (lsu_q.size() == `COMMIT_DEPTH);
        do_write  = 1'b0;
        took_mrg  = 1'b0;
        took_lsu  = 1'b0;
        wr_tag    = '0;
        turn_next = model_turn;
        if (!v.flush) begin
            if (model_turn == TURN_ITU) begin  // Buffered head first, else bypass.
                if (itu_q.size() != 0) begin
                    do_write = 1'b1;
                    wr_tag   = itu_q.pop_front();
                end else if (mrg_v) begin
                    do_write = 1'b1;
                    wr_tag   = v.mrg_tag;
                    took_mrg = 1'b1;
                end
                if (lsu_q.size() != 0) turn_next = TURN_LSU;
            end else begin
                if (lsu_q.size() != 0) begin
                    do_write = 1'b1;
                    wr_tag   = lsu_q.pop_front();
                end else if (v.lsu_v) begin
                    do_write = 1'b1;
                    wr_tag   = v.lsu_tag;
                    took_lsu = 1'b1;
                end
                if (itu_q.size() != 0) turn_next = TURN_ITU;
            end
        end
        #(CLK_PERIOD / 4);  // Sample midway between falling and rising edge.
        check_stall(exp_stall);
        check_write(do_write);
        if (do_write) check_rob(wr_tag, sb_result[wr_tag], sb_reg[wr_tag]);
        check_fwd(0, v.exp_v0 ? pend_result[v.src0] : '0, v.exp_v0);
        check_fwd(1, v.exp_v1 ? pend_result[v.src1] : '0, v.exp_v1);
        if (v.flush) begin  // Flushed tags never commit.
            foreach (itu_q[i]) begin
                sb_result.delete(itu_q[i]);
                sb_reg.delete(itu_q[i]);
            end
            foreach (lsu_q[i]) begin
                sb_result.delete(lsu_q[i]);
                sb_reg.delete(lsu_q[i]);
            end
            itu_q.delete();
            lsu_q.delete();
            foreach (pend_valid[r]) pend_valid[r] = 1'b0;
            model_turn = TURN_ITU;
        end else begin
            if (do_write) begin
                if (pend_valid[sb_reg[wr_tag]] && pend_tag[sb_reg[wr_tag]] == wr_tag)
                    pend_valid[sb_reg[wr_tag]] = 1'b0;
                sb_result.delete(wr_tag);
                sb_reg.delete(wr_tag);
            end
            if (mrg_v && !took_mrg) itu_q.push_back(v.mrg_tag);
            if (v.lsu_v && !took_lsu) lsu_q.push_back(v.lsu_tag);
            model_turn = turn_next;
        end
    endtask

    initial begin
        rst_n_i      = 1'b0;
        flush_i      = 1'b0;
        itu_valid_i  = 1'b0;
        itu_result_i = '0;
        itu_reg_i    = '0;
        itu_tag_i    = '0;
        csr_valid_i  = 1'b0;
        csr_result_i = '0;
        csr_reg_i    = '0;
        csr_tag_i    = '0;
        lsu_valid_i  = 1'b0;
        lsu_result_i = '0;
        lsu_reg_i    = '0;
        lsu_tag_i    = '0;
        src0_i       = '0;
        src1_i       = '0;
        model_turn   = TURN_ITU;
        foreach (pend_valid[r]) pend_valid[r] = 1'b0;
        repeat (2) @(posedge clk_i);  // Two cycles of reset.
        @(negedge clk_i);
        rst_n_i = 1'b1;
        #(CLK_PERIOD / 4);
        check_write(1'b0);  // Quiet after reset.
        check_stall(1'b0);
        check_fwd(0, '0, 1'b0);
        check_fwd(1, '0, 1'b0);
        for (int i = 0; i < NUM_VECS; i++) apply_cycle(vectors[i]);
        drain_cycles = 0;
        while ((itu_q.size() != 0 || lsu_q.size() != 0) && drain_cycles < DRAIN_LIMIT) begin
            apply_cycle(idle_row);
            drain_cycles++;
        end
        if (itu_q.size() != 0 || lsu_q.size() != 0) begin
            report_failure("Timed out waiting for the commit buffers to drain");
        end else if (sb_result.num() != 0) begin
            report_failure("Some issued results were never written to the ROB");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule : commit_stage_tb

/* project.f */
+incdir+include
+incdir+bench
hdl/commit_pkg.sv
hdl/commit_buffer.sv
hdl/commit_arbiter.sv
hdl/forward_select.sv
hdl/commit_stage.sv
bench/commit_stage_tb.sv
